//--- vcap_pkg.sv
/*
 * shared types and constants for the video capture front end
 * byte and word widths, fixed-point colour constants, state enums
 * imported by every design file that needs them
 */
package vcap_pkg;

	// ------------------------------
	// data widths
	// ------------------------------
	typedef logic [7:0]         byte_t;       // one decoder byte
	typedef logic [15:0]        word_t;       // frame buffer word
	typedef logic [4:0]         gray_t;       // gray level
	typedef logic signed [20:0] acc_t;        // products and sums
	typedef logic [14:0]        bank_addr_t;  // word address in a bank

	// ------------------------------
	// colour conversion, u2.8 fixed point
	// ------------------------------
	localparam logic [9:0] K_Y    = 10'd298;  // 1.164
	localparam logic [9:0] K_CR_R = 10'd408;  // 1.596
	localparam logic [9:0] K_CR_G = 10'd208;  // 0.813
	localparam logic [9:0] K_CB_G = 10'd100;  // 0.392
	localparam logic [9:0] K_CB_B = 10'd516;  // 2.017

	// black level and chroma zero on 8 bit data
	localparam int Y_OFFSET = 16;
	localparam int C_OFFSET = 128;

	// interrupt pulse length in clk_llc cycles
	localparam int IRQ_CYCLES = 2;

	// byte order within a 4:2:2 group
	typedef enum logic [1:0] {
		PH_CB,
		PH_Y0,
		PH_CR,
		PH_Y1
	} phase_t;

	// host read handshake
	typedef enum logic [1:0] {
		RD_IDLE,   // waiting for csx and rdx low
		RD_FETCH,  // waiting for a cycle with no write
		RD_HOLD    // data out until rdx rises
	} rd_state_t;

endpackage

//--- vcap_ifs.sv
/*
 * internal links of the capture path
 * sample_if carries decimated YCbCr samples into the colour converter
 * fb_write_if carries gray words into the frame buffer
 */
`timescale 1ns/10ps

interface sample_if;
	import vcap_pkg::*;

	logic  valid;      // one cycle strobe per kept group
	byte_t y;
	byte_t cb;
	byte_t cr;
	logic  field_end;  // cycle after odd field drops

	modport src (output valid, y, cb, cr, field_end);
	modport dst (input valid, y, cb, cr, field_end);
endinterface

interface fb_write_if;
	import vcap_pkg::*;

	logic       wr_en;  // no back-pressure
	logic       bank;
	bank_addr_t addr;
	word_t      data;

	modport src (output wr_en, bank, addr, data);
	modport dst (input wr_en, bank, addr, data);
endinterface

//--- video_sampler.sv
/*
 * byte stream front end for the video decoder
 * tracks the Cb Y0 Cr Y1 phase, keeps every DECIM_X group and every DECIM_Y line
 * of an odd field and emits one sample per kept group
 */
`timescale 1ns/10ps

module video_sampler #(
	parameter int DECIM_X = 2,
	parameter int DECIM_Y = 2
) (
	input  logic            clk_llc,
	input  logic            resetx,
	input  logic            href,
	input  logic            vref,
	input  logic            odd,
	input  vcap_pkg::byte_t vpo,
	sample_if.src           smp
);
	import vcap_pkg::*;

	localparam int XW = (DECIM_X > 1) ? $clog2(DECIM_X) : 1;
	localparam int YW = (DECIM_Y > 1) ? $clog2(DECIM_Y) : 1;

	logic          field_act;    // odd field in progress
	logic          field_act_d;
	logic          href_d;
	logic          href_rise;
	logic [YW-1:0] line_idx;     // line index mod DECIM_Y
	logic          line_keep_q;
	logic          line_kept;
	logic [XW-1:0] grp_idx;      // group index mod DECIM_X
	logic          grab;         // byte of a kept line
	phase_t        phase;

	assign field_act = odd & vref;
	assign href_rise = href & ~href_d;
	assign line_kept = href_rise ? (line_idx == '0) : line_keep_q;  // decided on first byte
	assign grab      = field_act & href & line_kept;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			href_d        <= 1'b0;
			field_act_d   <= 1'b0;
			line_idx      <= '0;
			line_keep_q   <= 1'b0;
			grp_idx       <= '0;
			phase         <= PH_CB;
			smp.valid     <= 1'b0;
			smp.field_end <= 1'b0;
		end
		else
		begin
			href_d        <= href;
			field_act_d   <= field_act;
			smp.field_end <= field_act_d & ~field_act;  // falling edge of field

			// line decimation
			if (!field_act)
			begin
				line_idx    <= '0;
				line_keep_q <= 1'b0;
			end
			else if (href_rise)
			begin
				line_keep_q <= (line_idx == '0);
				line_idx    <= (line_idx == YW'(DECIM_Y - 1)) ? '0 : line_idx + 1'b1;
			end

			// byte phase and group decimation
			if (grab)
			begin
				phase <= phase_t'(phase + 2'd1);  // wraps from Y1 to Cb
				if (phase == PH_Y1)
					grp_idx <= (grp_idx == XW'(DECIM_X - 1)) ? '0 : grp_idx + 1'b1;
			end
			else
			begin
				phase   <= PH_CB;
				grp_idx <= '0;
			end

			smp.valid <= grab & (phase == PH_Y1) & (grp_idx == '0);
		end
	end

	// sample payload of kept groups only
	always_ff @(posedge clk_llc)
	begin
		if (grab && grp_idx == '0)
		begin
			case (phase)
				PH_CB:   smp.cb <= vpo;
				PH_Y0:   smp.y  <= vpo;
				PH_CR:   smp.cr <= vpo;
				default: ;  // Y1 not used
			endcase
		end
	end

	// whole group inside the odd field, back to its Cb byte
	a_valid_in_field : assert property (@(posedge clk_llc) disable iff (!resetx)
		smp.valid |-> $past(field_act, 4));

endmodule

//--- ycc_to_gray.sv
/*
 * YCbCr to gray conversion in two register stages
 * stage 1 multiplies offset data by u2.8 constants, stage 2 sums to R G B
 * saturation and gray packing to RGB565 follow stage 2 combinationally
 */
`timescale 1ns/10ps

module ycc_to_gray (
	input  logic            clk_llc,
	input  logic            resetx,
	sample_if.dst           smp,
	output logic            pix_valid,
	output vcap_pkg::word_t pix_word,
	output logic            field_end
);
	import vcap_pkg::*;

	// constants widened to signed for the multiply
	localparam logic signed [10:0] KS_Y    = {1'b0, K_Y};
	localparam logic signed [10:0] KS_CR_R = {1'b0, K_CR_R};
	localparam logic signed [10:0] KS_CR_G = {1'b0, K_CR_G};
	localparam logic signed [10:0] KS_CB_G = {1'b0, K_CB_G};
	localparam logic signed [10:0] KS_CB_B = {1'b0, K_CB_B};

	logic signed [8:0] y_off;
	logic signed [8:0] cb_off;
	logic signed [8:0] cr_off;
	acc_t              p_y, p_cr_r, p_cr_g, p_cb_g, p_cb_b;  // stage 1
	acc_t              r_acc, g_acc, b_acc;                  // stage 2
	logic              v1, v2;
	logic              fe1, fe2;                             // field end delay line
	logic [7:0]        r_sat, g_sat, b_sat;
	logic [4:0]        r5;
	logic [5:0]        g6;
	logic [4:0]        b5;
	gray_t             gray;

	// clamp to the 8 bit integer part
	function automatic logic [7:0] clamp8(input acc_t a);
		if (a[20])
			return 8'h00;  // negative
		if (a[19:16] != 4'd0)
			return 8'hff;  // 256 or more
		return a[15:8];
	endfunction

	assign y_off  = $signed({1'b0, smp.y})  - 9'(Y_OFFSET);
	assign cb_off = $signed({1'b0, smp.cb}) - 9'(C_OFFSET);
	assign cr_off = $signed({1'b0, smp.cr}) - 9'(C_OFFSET);

	// ------------------------------
	// pipeline control
	// ------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			v1  <= 1'b0;
			v2  <= 1'b0;
			fe1 <= 1'b0;
			fe2 <= 1'b0;
		end
		else
		begin
			v1  <= smp.valid;
			v2  <= v1;
			fe1 <= smp.field_end;  // keeps field end behind the last pixel
			fe2 <= fe1;
		end
	end

	// ------------------------------
	// datapath
	// ------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (smp.valid)
		begin
			p_y    <= y_off  * KS_Y;
			p_cr_r <= cr_off * KS_CR_R;
			p_cr_g <= cr_off * KS_CR_G;
			p_cb_g <= cb_off * KS_CB_G;
			p_cb_b <= cb_off * KS_CB_B;
		end
		if (v1)
		begin
			r_acc <= p_y + p_cr_r;
			g_acc <= p_y - p_cr_g - p_cb_g;
			b_acc <= p_y + p_cb_b;
		end
	end

	assign r_sat = clamp8(r_acc);
	assign g_sat = clamp8(g_acc);
	assign b_sat = clamp8(b_acc);
	assign r5    = r_sat[7:3];
	assign g6    = g_sat[7:2];
	assign b5    = b_sat[7:3];

	// R/4 + G/4 + B/8, at most 25
	assign gray = gray_t'(r5 >> 2) + gray_t'(g6 >> 2) + gray_t'(b5 >> 3);

	assign pix_word  = {gray, gray, 1'b0, gray};  // 565 with gray in every channel
	assign pix_valid = v2;
	assign field_end = fe2;

endmodule

//--- frame_writer.sv
/*
 * frame bank write side
 * stores each gray word at the running address of the current bank and
 * pulses that bank's interrupt at field end before switching banks
 */
`timescale 1ns/10ps

module frame_writer #(
	parameter int BANK_WORDS = 32768
) (
	input  logic            clk_llc,
	input  logic            resetx,
	input  logic            pix_valid,
	input  vcap_pkg::word_t pix_word,
	input  logic            field_end,
	fb_write_if.src         wr,
	output logic            irq0,
	output logic            irq1
);
	import vcap_pkg::*;

	localparam int         CW        = $clog2(IRQ_CYCLES + 1);
	localparam bank_addr_t ADDR_LAST = bank_addr_t'(BANK_WORDS - 1);

	logic          bank_q;   // bank being filled
	bank_addr_t    addr_q;
	logic [CW-1:0] irq_cnt;  // cycles of interrupt left
	logic          irq_on;

	// one word per pixel, straight through
	assign wr.wr_en = pix_valid;
	assign wr.bank  = bank_q;
	assign wr.addr  = addr_q;
	assign wr.data  = pix_word;

	assign irq_on = (irq_cnt != '0);
	assign irq0   = irq_on & ~bank_q;
	assign irq1   = irq_on & bank_q;

	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			bank_q  <= 1'b0;  // first field into bank 0
			addr_q  <= '0;
			irq_cnt <= '0;
		end
		else
		begin
			if (field_end)
				irq_cnt <= CW'(IRQ_CYCLES);
			else if (irq_on)
				irq_cnt <= irq_cnt - 1'b1;

			if (irq_cnt == CW'(1))
			begin
				bank_q <= ~bank_q;  // swap once the pulse is out
				addr_q <= '0;
			end
			else if (pix_valid && addr_q != ADDR_LAST)
				addr_q <= addr_q + 1'b1;  // holds at the last word
		end
	end

	// banks strictly alternate so interrupts never overlap or touch
	a_irq_excl : assert property (@(posedge clk_llc) disable iff (!resetx)
		!(irq0 && irq1) && !(irq0 && $past(irq1)) && !(irq1 && $past(irq0)));

	a_addr_range : assert property (@(posedge clk_llc) disable iff (!resetx)
		wr.addr < BANK_WORDS);

endmodule

//--- frame_buffer_arb.sv
/*
 * two bank frame memory shared by the capture path and the host
 * capture writes always win the port, a host read waits for a free cycle
 * host_waitx stays low until the read data is registered
 */
`timescale 1ns/10ps

module frame_buffer_arb #(
	parameter int BANK_WORDS = 32768
) (
	input  logic                                   clk_llc,
	input  logic                                   resetx,
	fb_write_if.dst                                wr,
	input  logic                                   host_csx,
	input  logic                                   host_rdx,
	input  logic [$bits(vcap_pkg::bank_addr_t):0] host_adr,
	output vcap_pkg::word_t                        host_rdata,
	output logic                                   host_waitx
);
	import vcap_pkg::*;

	localparam int AW = $bits(bank_addr_t);
	localparam int IW = $clog2(BANK_WORDS);  // index bits actually decoded

	word_t      mem0 [BANK_WORDS];
	word_t      mem1 [BANK_WORDS];
	word_t      rdata_q;
	rd_state_t  rd_state;
	logic       rd_req;    // host strobes both low
	logic       rd_go;     // fetch this cycle
	logic       data_rdy;  // registered read data valid
	logic       rd_bank;
	bank_addr_t rd_addr;

	assign rd_req  = ~host_csx & ~host_rdx;
	assign rd_go   = (rd_state == RD_FETCH) & ~wr.wr_en;  // port free
	assign rd_bank = host_adr[AW];
	assign rd_addr = host_adr[AW-1:0];

	assign host_rdata = rdata_q;
	assign host_waitx = data_rdy & ~((rd_state == RD_IDLE) & rd_req);  // drop on request

	// ------------------------------
	// memory port
	// ------------------------------
	always_ff @(posedge clk_llc)
	begin
		if (wr.wr_en)
		begin
			if (wr.bank)
				mem1[wr.addr[IW-1:0]] <= wr.data;
			else
				mem0[wr.addr[IW-1:0]] <= wr.data;
		end
		else if (rd_go)
			rdata_q <= rd_bank ? mem1[rd_addr[IW-1:0]] : mem0[rd_addr[IW-1:0]];
	end

	// ------------------------------
	// host read FSM
	// ------------------------------
	always_ff @(posedge clk_llc or negedge resetx)
	begin
		if (!resetx)
		begin
			rd_state <= RD_IDLE;
			data_rdy <= 1'b1;
		end
		else
		begin
			case (rd_state)
				RD_IDLE:
					if (rd_req)
					begin
						rd_state <= RD_FETCH;
						data_rdy <= 1'b0;
					end
				RD_FETCH:
					if (rd_go)
					begin
						rd_state <= RD_HOLD;  // data out next cycle
						data_rdy <= 1'b1;
					end
				RD_HOLD:
					if (host_rdx || host_csx)
						rd_state <= RD_IDLE;
				default:
					rd_state <= RD_IDLE;
			endcase
		end
	end

	a_wait_idle : assert property (@(posedge clk_llc) disable iff (!resetx)
		(rd_state == RD_IDLE && !rd_req) |-> host_waitx);

endmodule

//--- vcap_top.sv
/*
 * video capture front end top level
 * decoder byte stream in, two gray frame banks readable by the host bus
 * one interrupt per completed bank
 */
`timescale 1ns/10ps

module vcap_top #(
	parameter int BANK_WORDS = 32768,
	parameter int DECIM_X    = 2,
	parameter int DECIM_Y    = 2
) (
	input  logic                                   clk_llc,
	input  logic                                   resetx,
	input  logic                                   href,
	input  logic                                   vref,
	input  logic                                   odd,
	input  vcap_pkg::byte_t                        vpo,
	input  logic                                   host_csx,
	input  logic                                   host_rdx,
	input  logic [$bits(vcap_pkg::bank_addr_t):0] host_adr,
	output vcap_pkg::word_t                        host_rdata,
	output logic                                   host_waitx,
	output logic                                   irq0,
	output logic                                   irq1
);
	import vcap_pkg::*;

	logic  pix_valid;
	word_t pix_word;
	logic  pix_field_end;  // aligned with the last pixel

	sample_if   smp_if ();
	fb_write_if wr_if ();

	video_sampler #(.DECIM_X(DECIM_X), .DECIM_Y(DECIM_Y)) u_sampler (
		.clk_llc (clk_llc),
		.resetx  (resetx),
		.href    (href),
		.vref    (vref),
		.odd     (odd),
		.vpo     (vpo),
		.smp     (smp_if)
	);

	ycc_to_gray u_gray (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.smp       (smp_if),
		.pix_valid (pix_valid),
		.pix_word  (pix_word),
		.field_end (pix_field_end)
	);

	frame_writer #(.BANK_WORDS(BANK_WORDS)) u_writer (
		.clk_llc   (clk_llc),
		.resetx    (resetx),
		.pix_valid (pix_valid),
		.pix_word  (pix_word),
		.field_end (pix_field_end),
		.wr        (wr_if),
		.irq0      (irq0),
		.irq1      (irq1)
	);

	frame_buffer_arb #(.BANK_WORDS(BANK_WORDS)) u_fbuf (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.wr         (wr_if),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_adr   (host_adr),
		.host_rdata (host_rdata),
		.host_waitx (host_waitx)
	);

endmodule

//--- tb_vcap_model.svh
/*
 * reference model for the capture testbench, included inside tb_vcap
 * random bytes from a Fibonacci LFSR, expected gray words, value checks
 */
`ifndef TB_VCAP_MODEL_SVH
`define TB_VCAP_MODEL_SVH

// ------------------------------
// stimulus source
// ------------------------------

// x^32 + x^22 + x^2 + x + 1, one step per bit taken
function automatic logic [31:0] rand_bits(input int n);
	logic [31:0] r;
	logic        fb;
	r = '0;
	for (int i = 0; i < n; i++)
	begin
		fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		r          = {r[30:0], fb};
	end
	return r;
endfunction

// ------------------------------
// colour model
// ------------------------------

// value in units of 1/256, clipped to 0..255
function automatic int sat8(input int v);
	if (v < 0)
		return 0;
	if (v >= 256 * 256)
		return 255;
	return v / 256;
endfunction

// expected RGB565 gray word for one kept sample
function automatic word_t ref_gray_word(input byte_t y, input byte_t cb, input byte_t cr);
	int yo, cbo, cro;
	int r8, g8, b8;
	int gray;
	yo  = int'(y) - 16;   // black level
	cbo = int'(cb) - 128;
	cro = int'(cr) - 128;
	r8  = sat8(yo * 298 + cro * 408);               // 1.164 Y + 1.596 Cr
	g8  = sat8(yo * 298 - cro * 208 - cbo * 100);   // 0.813 Cr, 0.392 Cb
	b8  = sat8(yo * 298 + cbo * 516);               // 2.017 Cb
	gray = (r8 / 8) / 4 + (g8 / 4) / 4 + (b8 / 8) / 8;
	return word_t'((gray << 11) | (gray << 6) | gray);  // G gets gray * 2
endfunction

// ------------------------------
// checking
// ------------------------------
task automatic compare_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
	checks++;
	if (got !== exp)
	begin
		errors++;
		$display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
	end
endtask

task automatic note_failure(input string what);
	errors++;
	$display("ERROR at %0t: %s", $time, what);
endtask

`endif

//--- tb_vcap.sv
/*
 * testbench for the video capture front end
 * drives odd, even and saturating fields from an LFSR, checks interrupts
 * and reads both banks over the host bus against the model
 */
`timescale 1ns/10ps

module tb_vcap;
	import vcap_pkg::*;

	localparam int BANK_WORDS   = 512;
	localparam int DECIM_X      = 2;
	localparam int DECIM_Y      = 2;
	localparam int LINES        = 12;
	localparam int LINE_BYTES   = 64;  // 32 pixels of 4:2:2
	localparam int HREF_GAP     = 4;
	localparam int KEPT_WORDS   = (LINES / DECIM_Y) * (LINE_BYTES / 4 / DECIM_X);
	localparam int IRQ_TIMEOUT  = 200;
	localparam int WAIT_TIMEOUT = 500;
	localparam int EVEN_SETTLE  = 40;

	logic                        clk_llc;
	logic                        resetx;
	logic                        href;
	logic                        vref;
	logic                        odd;
	byte_t                       vpo;
	logic                        host_csx;
	logic                        host_rdx;
	logic [$bits(bank_addr_t):0] host_adr;
	word_t                       host_rdata;
	logic                        host_waitx;
	logic                        irq0;
	logic                        irq1;

	logic [31:0] lfsr_state;
	int          errors;
	int          checks;
	word_t       exp_bank0[$];  // model contents per bank
	word_t       exp_bank1[$];
	int          irq0_count, irq1_count;
	int          exp_irq0, exp_irq1;
	int          irq0_len, irq1_len;
	logic        irq0_d, irq1_d;
	bit          next_bank;     // bank the next odd field fills
	int          wait_min, wait_max;

	`include "tb_vcap_model.svh"

	vcap_top #(.BANK_WORDS(BANK_WORDS), .DECIM_X(DECIM_X), .DECIM_Y(DECIM_Y)) dut (
		.clk_llc    (clk_llc),
		.resetx     (resetx),
		.href       (href),
		.vref       (vref),
		.odd        (odd),
		.vpo        (vpo),
		.host_csx   (host_csx),
		.host_rdx   (host_rdx),
		.host_adr   (host_adr),
		.host_rdata (host_rdata),
		.host_waitx (host_waitx),
		.irq0       (irq0),
		.irq1       (irq1)
	);

	initial
	begin
		clk_llc = 1'b0;
		forever #5 clk_llc = ~clk_llc;
	end

	// irq edge counts and pulse widths sampled mid cycle
	always @(negedge clk_llc)
	begin
		if (resetx)
		begin
			if (irq0 && !irq0_d)
				irq0_count++;
			if (irq1 && !irq1_d)
				irq1_count++;
			if (irq0)
				irq0_len++;
			else if (irq0_d)
			begin
				compare_value("irq0 pulse length", irq0_len, IRQ_CYCLES);
				irq0_len = 0;
			end
			if (irq1)
				irq1_len++;
			else if (irq1_d)
			begin
				compare_value("irq1 pulse length", irq1_len, IRQ_CYCLES);
				irq1_len = 0;
			end
		end
		irq0_d = irq0;
		irq1_d = irq1;
	end

	// ------------------------------
	// video side
	// ------------------------------

	// one field of LINES lines with model words to the given bank
	task automatic drive_field(input bit odd_field, input bit extremes, input bit bank);
		byte_t grp [4];
		int    l, g, k;
		if (odd_field && bank)
			exp_bank1.delete();
		else if (odd_field)
			exp_bank0.delete();
		@(posedge clk_llc);
		#1;
		odd  = odd_field;
		vref = 1'b1;
		repeat (HREF_GAP)
			@(posedge clk_llc);
		for (l = 0; l < LINES; l++)
		begin
			for (g = 0; g < LINE_BYTES / 4; g++)
			begin
				for (k = 0; k < 4; k++)
				begin
					grp[k] = extremes ? (rand_bits(1) ? 8'hff : 8'h00) : byte_t'(rand_bits(8));
					@(posedge clk_llc);
					#1;
					href = 1'b1;
					vpo  = grp[k];  // Cb Y0 Cr Y1
				end
				if (odd_field && (l % DECIM_Y == 0) && (g % DECIM_X == 0))
				begin
					if (bank)
						exp_bank1.push_back(ref_gray_word(grp[1], grp[0], grp[2]));
					else
						exp_bank0.push_back(ref_gray_word(grp[1], grp[0], grp[2]));
				end
			end
			@(posedge clk_llc);
			#1;
			href = 1'b0;
			vpo  = 8'h00;
			repeat (HREF_GAP - 1)
				@(posedge clk_llc);
		end
		#1;
		vref = 1'b0;  // field over
		odd  = 1'b0;
	endtask

	// waits until the irq counts reach the expected totals
	task automatic await_field_irq(input string tag);
		int n;
		n = 0;
		while ((irq0_count + irq1_count) < (exp_irq0 + exp_irq1) && n < IRQ_TIMEOUT)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (n >= IRQ_TIMEOUT)
			note_failure({tag, ": no field interrupt arrived in time"});
		compare_value({tag, " irq0 count"}, irq0_count, exp_irq0);
		compare_value({tag, " irq1 count"}, irq1_count, exp_irq1);
	endtask

	task automatic capture_odd_field(input bit extremes, input string tag);
		drive_field(1'b1, extremes, next_bank);
		if (next_bank)
			exp_irq1++;
		else
			exp_irq0++;
		await_field_irq(tag);
		next_bank = ~next_bank;
	endtask

	// ------------------------------
	// host side
	// ------------------------------
	task automatic host_read(input bit bank, input int addr, output word_t data,
			output int waited, output bit ok);
		@(posedge clk_llc);
		#1;
		host_adr = {bank, bank_addr_t'(addr)};
		host_csx = 1'b0;
		host_rdx = 1'b0;
		waited   = 0;
		ok       = 1'b0;
		while (!ok && waited < WAIT_TIMEOUT)
		begin
			@(negedge clk_llc);
			if (host_waitx)
				ok = 1'b1;
			else
				waited++;
		end
		data = host_rdata;
		if (!ok)
			note_failure($sformatf("host read of bank%0d[%0d] never ended its wait", bank, addr));
		@(posedge clk_llc);
		#1;
		host_rdx = 1'b1;  // high at least one edge before the next read
		host_csx = 1'b1;
	endtask

	task automatic check_bank(input bit bank, input string tag);
		word_t data;
		int    waited;
		bit    ok;
		for (int i = 0; i < KEPT_WORDS; i++)
		begin
			host_read(bank, i, data, waited, ok);
			if (ok)
				compare_value($sformatf("%s host_rdata bank%0d[%0d]", tag, bank, i), data,
					bank ? exp_bank1[i] : exp_bank0[i]);
		end
	endtask

	// reads one bank while the other one is being filled
	task automatic reads_during_capture(input bit bank);
		word_t data;
		int    waited;
		bit    ok;
		int    n;
		n = 0;
		while (!href && n < WAIT_TIMEOUT)
		begin
			@(negedge clk_llc);
			n++;
		end
		if (n >= WAIT_TIMEOUT)
			note_failure("field never started before the concurrent reads");
		wait_min = WAIT_TIMEOUT;
		wait_max = 0;
		for (int i = 0; i < KEPT_WORDS; i++)
		begin
			repeat (i % 3)
				@(posedge clk_llc);  // shifts read phase against the writes
			host_read(bank, i, data, waited, ok);
			if (ok)
			begin
				compare_value($sformatf("busy host_rdata bank%0d[%0d]", bank, i), data,
					bank ? exp_bank1[i] : exp_bank0[i]);
				wait_min = (waited < wait_min) ? waited : wait_min;
				wait_max = (waited > wait_max) ? waited : wait_max;
			end
		end
		$display("reads under capture waited %0d to %0d cycles", wait_min, wait_max);
		if (wait_max <= wait_min)
			note_failure("no read under capture was held off by a write");
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial
	begin
		resetx     = 1'b0;
		href       = 1'b0;
		vref       = 1'b0;
		odd        = 1'b0;
		vpo        = 8'h00;
		host_csx   = 1'b1;
		host_rdx   = 1'b1;
		host_adr   = '0;
		lfsr_state = 32'h9f18;
		errors     = 0;
		checks     = 0;
		irq0_count = 0;
		irq1_count = 0;
		exp_irq0   = 0;
		exp_irq1   = 0;
		irq0_len   = 0;
		irq1_len   = 0;
		irq0_d     = 1'b0;
		irq1_d     = 1'b0;
		next_bank  = 1'b0;

		repeat (16)
			@(posedge clk_llc);
		#1;
		resetx = 1'b1;

		@(negedge clk_llc);
		compare_value("irq0 after reset", irq0, 1'b0);
		compare_value("irq1 after reset", irq1, 1'b0);
		compare_value("host_waitx after reset", host_waitx, 1'b1);

		capture_odd_field(1'b0, "field 1");  // bank 0
		check_bank(1'b0, "field 1");

		capture_odd_field(1'b0, "field 2");  // bank 1
		check_bank(1'b1, "field 2");
		check_bank(1'b0, "field 2");

		// even field moves nothing
		drive_field(1'b0, 1'b0, next_bank);
		repeat (EVEN_SETTLE)
			@(negedge clk_llc);
		compare_value("even field irq0 count", irq0_count, exp_irq0);
		compare_value("even field irq1 count", irq1_count, exp_irq1);
		check_bank(1'b0, "even field");
		check_bank(1'b1, "even field");

		capture_odd_field(1'b1, "extremes");  // bank 0 with bytes 00 and ff only
		check_bank(1'b0, "extremes");

		// bank 1 fills while bank 0 is read
		fork
			drive_field(1'b1, 1'b0, next_bank);
			reads_during_capture(~next_bank);
		join
		if (next_bank)
			exp_irq1++;
		else
			exp_irq0++;
		await_field_irq("field 4");
		next_bank = ~next_bank;
		check_bank(1'b1, "field 4");

		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
vcap_pkg.sv
vcap_ifs.sv
video_sampler.sv
ycc_to_gray.sv
frame_writer.sv
frame_buffer_arb.sv
vcap_top.sv
tb_vcap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the capture testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module tb_vcap -o sim_vcap

# the log decides the result
./obj_dir/sim_vcap | tee sim.log

if grep -q "^CHECKS FAILED$" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi

echo "simulation finished without failures"
exit 0
